// ==== logic/cache_pkg.sv ====
package cache_pkg;

  // Cache geometry
  // Two ways only, since one LRU bit per set names the victim
  localparam int NUM_WAYS = 2;
  localparam int WORDS_PER_LINE = 4;

  // Byte address from the requester
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [31:0] word_t;

  // Whole cache line, word 0 in the low bits
  typedef logic [127:0] line_t;

  // Word offset within a line
  typedef logic [1:0] word_sel_t;

  // Line index into backing memory
  // Wider than needed, the memory keeps only the low bits
  typedef logic [31:0] mem_addr_t;

  // Request from the processor side
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } cache_req_t;

  // Response back to the processor side
  typedef struct packed {
    logic  write;
    logic  hit;
    // Read data, or the stored word for a write
    word_t rdata;
  } cache_resp_t;

  // Controller FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_RESPOND
  } ctrl_state_t;

endpackage

// ==== logic/req_intake.sv ====
`timescale 1ns/1ns

module req_intake #(
  parameter int REQ_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  req_credit,
  input  logic                  take,
  output logic                  pending,
  output cache_pkg::cache_req_t head
);

  // Pointer and fill count widths
  localparam int PTR_BITS = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(REQ_DEPTH + 1);

  // Request storage
  cache_pkg::cache_req_t fifo_mem [REQ_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  // Pop only when an entry is waiting
  assign pop = take && pending;

  // Head is valid whenever the FIFO holds an entry
  assign pending = (count != '0);
  assign head = fifo_mem[rd_ptr];

  // Each consumed entry frees a slot for the requester
  assign req_credit = pop;

  // Storage write
  always_ff @(posedge clk) begin
    if (req_valid) begin
      fifo_mem[wr_ptr] <= req;
    end
  end

  // Pointers and fill count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous write and pop leaves the count unchanged
      count <= count + CNT_BITS'(req_valid) - CNT_BITS'(pop);
    end
  end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl #(
  parameter int NUM_SETS = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pending,
  input  cache_pkg::cache_req_t  head,
  output logic                   take,
  output logic                   mem_start,
  output logic                   mem_write,
  output cache_pkg::mem_addr_t   mem_line_addr,
  output cache_pkg::line_t       mem_wdata,
  input  logic                   mem_done,
  input  cache_pkg::line_t       mem_rdata,
  output logic                   push,
  output cache_pkg::cache_resp_t push_resp,
  input  logic                   full
);

  // Address split is tag, set, word, byte
  localparam int OFFSET_BITS = $clog2(cache_pkg::WORDS_PER_LINE) + 2;
  localparam int SET_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;
  localparam int WORD_BITS = $bits(cache_pkg::word_t);

  typedef logic [SET_BITS-1:0] set_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  cache_pkg::ctrl_state_t state;

  // Tag and line storage, no reset
  tag_t             tag_arr  [NUM_SETS][cache_pkg::NUM_WAYS];
  cache_pkg::line_t data_arr [NUM_SETS][cache_pkg::NUM_WAYS];
  // Status bits per set and way
  logic [cache_pkg::NUM_WAYS-1:0] valid_arr [NUM_SETS];
  logic [cache_pkg::NUM_WAYS-1:0] dirty_arr [NUM_SETS];
  // Way to replace next in each set
  logic [NUM_SETS-1:0] lru_arr;

  // Request in service and its chosen victim
  cache_pkg::cache_req_t req_q;
  logic                  victim_q;

  set_t                           req_set;
  tag_t                           req_tag;
  cache_pkg::word_sel_t           req_sel;
  logic [cache_pkg::NUM_WAYS-1:0] way_hit;
  logic                           hit;
  logic                           victim_way;
  logic                           victim_dirty;
  logic                           do_hit;
  logic                           do_miss;
  logic                           wb_done;
  logic                           fill_done;
  logic                           complete;
  logic                           acc_way;
  cache_pkg::line_t               acc_line;
  cache_pkg::word_t               acc_word;
  cache_pkg::mem_addr_t           fill_addr;

  // Replace one word of a line
  function automatic cache_pkg::line_t merge_word(cache_pkg::line_t line,
                                                  cache_pkg::word_sel_t sel,
                                                  cache_pkg::word_t data);
    cache_pkg::line_t merged;
    merged = line;
    merged[sel*WORD_BITS +: WORD_BITS] = data;
    return merged;
  endfunction

  assign req_set = req_q.addr[OFFSET_BITS +: SET_BITS];
  assign req_tag = req_q.addr[31 -: TAG_BITS];
  assign req_sel = req_q.addr[OFFSET_BITS-1:2];
  assign fill_addr = cache_pkg::mem_addr_t'(req_q.addr[31:OFFSET_BITS]);

  // Tag compare across both ways
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      way_hit[w] = valid_arr[req_set][w] && (tag_arr[req_set][w] == req_tag);
    end
  end
  assign hit = |way_hit;

  // Empty way first, LRU way otherwise
  assign victim_way = !valid_arr[req_set][0] ? 1'b0 :
                      !valid_arr[req_set][1] ? 1'b1 : lru_arr[req_set];
  assign victim_dirty = valid_arr[req_set][victim_way] && dirty_arr[req_set][victim_way];

  // Event strobes
  assign do_hit    = (state == cache_pkg::ST_LOOKUP) && hit;
  assign do_miss   = (state == cache_pkg::ST_LOOKUP) && !hit;
  assign wb_done   = (state == cache_pkg::ST_WRITEBACK) && mem_done;
  assign fill_done = (state == cache_pkg::ST_REFILL) && mem_done;
  assign complete  = do_hit || fill_done;

  // After refill the access runs on the fresh line like a hit
  assign acc_way  = fill_done ? victim_q : way_hit[1];
  assign acc_line = fill_done ? mem_rdata : data_arr[req_set][acc_way];
  assign acc_word = acc_line[req_sel*WORD_BITS +: WORD_BITS];

  assign take = (state == cache_pkg::ST_IDLE) && pending;
  assign push = (state == cache_pkg::ST_RESPOND) && !full;

  // FSM, status bits and memory strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= cache_pkg::ST_IDLE;
      mem_start <= 1'b0;
      mem_write <= 1'b0;
      lru_arr   <= '0;
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_arr[s] <= '0;
        dirty_arr[s] <= '0;
      end
    end else begin
      mem_start <= 1'b0;
      case (state)
        cache_pkg::ST_IDLE: begin
          if (pending) state <= cache_pkg::ST_LOOKUP;
        end
        cache_pkg::ST_LOOKUP: begin
          if (hit) begin
            state <= cache_pkg::ST_RESPOND;
          end else begin
            // Dirty victim goes out before the refill
            mem_start <= 1'b1;
            mem_write <= victim_dirty;
            state     <= victim_dirty ? cache_pkg::ST_WRITEBACK : cache_pkg::ST_REFILL;
          end
        end
        cache_pkg::ST_WRITEBACK: begin
          if (mem_done) begin
            mem_start <= 1'b1;
            mem_write <= 1'b0;
            state     <= cache_pkg::ST_REFILL;
          end
        end
        cache_pkg::ST_REFILL: begin
          if (mem_done) state <= cache_pkg::ST_RESPOND;
        end
        cache_pkg::ST_RESPOND: begin
          // Hold here while the response queue is full
          if (!full) state <= cache_pkg::ST_IDLE;
        end
        default: state <= cache_pkg::ST_IDLE;
      endcase
      if (complete) begin
        valid_arr[req_set][acc_way] <= 1'b1;
        // Refilled line is clean unless this access writes it
        dirty_arr[req_set][acc_way] <= req_q.write || (do_hit && dirty_arr[req_set][acc_way]);
        lru_arr[req_set]            <= ~acc_way;
      end
    end
  end

  // Request, line data and memory payload
  always_ff @(posedge clk) begin
    if (take) req_q <= head;
    if (do_miss) begin
      victim_q      <= victim_way;
      mem_wdata     <= data_arr[req_set][victim_way];
      mem_line_addr <= victim_dirty ?
                       cache_pkg::mem_addr_t'({tag_arr[req_set][victim_way], req_set}) :
                       fill_addr;
    end
    if (wb_done) mem_line_addr <= fill_addr;
    if (complete) begin
      tag_arr[req_set][acc_way]  <= req_tag;
      data_arr[req_set][acc_way] <= req_q.write ? merge_word(acc_line, req_sel, req_q.wdata) :
                                                  acc_line;
      push_resp.write <= req_q.write;
      push_resp.hit   <= do_hit;
      push_resp.rdata <= req_q.write ? req_q.wdata : acc_word;
    end
  end

endmodule

// ==== logic/line_memory.sv ====
`timescale 1ns/1ns

module line_memory #(
  parameter int MEM_LINES   = 256,
  parameter int MEM_LATENCY = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_start,
  input  logic                 mem_write,
  input  cache_pkg::mem_addr_t mem_line_addr,
  input  cache_pkg::line_t     mem_wdata,
  output logic                 mem_done,
  output cache_pkg::line_t     mem_rdata
);

  localparam int IDX_BITS = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  // Line storage
  cache_pkg::line_t line_mem [MEM_LINES];

  // Operation captured at start
  logic [IDX_BITS-1:0] idx_q;
  logic                write_q;
  cache_pkg::line_t    wdata_q;

  // Latency counter
  logic                busy;
  logic [CNT_BITS-1:0] cnt;

  // Memory comes up all zero
  initial begin
    for (int i = 0; i < MEM_LINES; i++) begin
      line_mem[i] = '0;
    end
  end

  // Done in the cycle the counter reaches zero
  assign mem_done  = busy && (cnt == '0);
  assign mem_rdata = line_mem[idx_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (mem_start) begin
      busy <= 1'b1;
      cnt  <= CNT_BITS'(MEM_LATENCY - 1);
    end else if (mem_done) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Capture the request, commit writes on completion
  always_ff @(posedge clk) begin
    if (mem_start) begin
      idx_q   <= IDX_BITS'(mem_line_addr % MEM_LINES);
      write_q <= mem_write;
      wdata_q <= mem_wdata;
    end
    if (mem_done && write_q) begin
      line_mem[idx_q] <= wdata_q;
    end
  end

endmodule

// ==== logic/resp_queue.sv ====
`timescale 1ns/1ns

module resp_queue #(
  parameter int RESP_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  cache_pkg::cache_resp_t push_resp,
  output logic                   full,
  output logic                   resp_valid,
  output cache_pkg::cache_resp_t resp,
  input  logic                   resp_credit
);

  localparam int PTR_BITS = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(RESP_DEPTH + 1);

  cache_pkg::cache_resp_t fifo_mem [RESP_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  // Consumer credits on hand
  logic [CNT_BITS-1:0] credits;

  assign full = (count == CNT_BITS'(RESP_DEPTH));

  // Send needs both data and a credit
  assign resp_valid = (count != '0) && (credits != '0);
  assign resp = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= push_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CNT_BITS'(RESP_DEPTH);
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (resp_valid) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(resp_valid);
      // Send and returned credit may coincide
      credits <= credits + CNT_BITS'(resp_credit) - CNT_BITS'(resp_valid);
    end
  end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ns

module cache_top #(
  parameter int NUM_SETS    = 8,
  parameter int REQ_DEPTH   = 4,
  parameter int RESP_DEPTH  = 4,
  parameter int MEM_LINES   = 256,
  parameter int MEM_LATENCY = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_req_t  req,
  output logic                   req_credit,
  output logic                   resp_valid,
  output cache_pkg::cache_resp_t resp,
  input  logic                   resp_credit
);

  // Intake to controller
  logic                  pending;
  logic                  take;
  cache_pkg::cache_req_t head;

  // Controller to backing memory
  logic                 mem_start;
  logic                 mem_write;
  cache_pkg::mem_addr_t mem_line_addr;
  cache_pkg::line_t     mem_wdata;
  logic                 mem_done;
  cache_pkg::line_t     mem_rdata;

  // Controller to response queue
  logic                   push;
  logic                   full;
  cache_pkg::cache_resp_t push_resp;

  req_intake #(.REQ_DEPTH(REQ_DEPTH)) i_req_intake (
    .clk, .reset, .req_valid, .req, .req_credit, .take, .pending, .head
  );

  cache_ctrl #(.NUM_SETS(NUM_SETS)) i_cache_ctrl (
    .clk, .reset, .pending, .head, .take,
    .mem_start, .mem_write, .mem_line_addr, .mem_wdata, .mem_done, .mem_rdata,
    .push, .push_resp, .full
  );

  line_memory #(
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) i_line_memory (
    .clk, .reset, .mem_start, .mem_write, .mem_line_addr, .mem_wdata, .mem_done, .mem_rdata
  );

  resp_queue #(.RESP_DEPTH(RESP_DEPTH)) i_resp_queue (
    .clk, .reset, .push, .push_resp, .full, .resp_valid, .resp, .resp_credit
  );

endmodule

// ==== sim/cache_asserts.sv ====
`timescale 1ns/1ns

module cache_asserts #(
  parameter int REQ_DEPTH  = 4,
  parameter int RESP_DEPTH = 4
) (
  input logic clk,
  input logic reset,
  input logic req_valid,
  input logic take,
  input logic resp_valid,
  input logic resp_credit,
  input logic mem_start,
  input logic mem_done
);

  // Shadow intake fill, consumer credits and memory busy flag
  int   intake_fill;
  int   resp_credits;
  logic mem_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      intake_fill  <= 0;
      resp_credits <= RESP_DEPTH;
      mem_busy     <= 1'b0;
    end else begin
      intake_fill  <= intake_fill + int'(req_valid) - int'(take);
      resp_credits <= resp_credits + int'(resp_credit) - int'(resp_valid);
      if (mem_start) mem_busy <= 1'b1;
      else if (mem_done) mem_busy <= 1'b0;
    end
  end

  a_intake_room: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> (intake_fill < REQ_DEPTH))
    else $error("request written into a full intake FIFO");

  a_resp_credit: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (resp_credits > 0))
    else $error("response sent with no consumer credit");

  a_mem_single: assert property (@(posedge clk) disable iff (reset)
    mem_start |-> !mem_busy)
    else $error("memory start while an operation is outstanding");

endmodule

// Top level sees the intake, response queue and memory handshakes
bind cache_top cache_asserts #(
  .REQ_DEPTH (REQ_DEPTH),
  .RESP_DEPTH(RESP_DEPTH)
) i_cache_asserts (
  .clk, .reset, .req_valid, .take, .resp_valid, .resp_credit, .mem_start, .mem_done
);

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

  localparam int NUM_SETS = 8;
  localparam int REQ_DEPTH = 4;
  localparam int RESP_DEPTH = 4;
  // Tag sits above 4 offset bits and the set bits
  localparam int TAG_LSB = 4 + $clog2(NUM_SETS);
  // Tests stay below byte address 4096, so 256 lines and no memory aliasing
  localparam int MEM_WORDS = 1024;
  // Request counts per test, summed for the cycle limit
  localparam int T1_REQS = 2 * NUM_SETS;
  localparam int T2_REQS = 6;
  localparam int T3_REQS = NUM_SETS;
  localparam int T4_REQS = 300;
  localparam int T5_REQS = 100;
  localparam int NUM_REQS = T1_REQS + T2_REQS + T3_REQS + T4_REQS + T5_REQS;
  localparam int CYCLE_LIMIT = 400 * NUM_REQS;

  logic                   clk;
  logic                   reset;
  logic                   req_valid;
  cache_pkg::cache_req_t  req;
  logic                   req_credit;
  logic                   resp_valid;
  cache_pkg::cache_resp_t resp;
  logic                   resp_credit;

  // Reference cache state and word memory
  cache_pkg::word_t               ref_mem [MEM_WORDS];
  cache_pkg::addr_t               ref_tag [NUM_SETS][cache_pkg::NUM_WAYS];
  logic [cache_pkg::NUM_WAYS-1:0] ref_valid [NUM_SETS];
  logic                           ref_lru [NUM_SETS];

  // Expected responses, written at request time and read by the compare process
  cache_pkg::cache_resp_t exp_mem [NUM_REQS];
  int exp_rd = 0;
  int sent;
  int stall_cycles;
  int errors = 0;
  int checks = 0;
  // Request credits seen and responses absorbed by the consumer
  int credits_back = 0;
  int absorbed = 0;
  logic        slow_consumer;
  logic [31:0] stim_lfsr;
  logic [31:0] credit_lfsr;

  cache_top #(
    .NUM_SETS   (NUM_SETS),
    .REQ_DEPTH  (REQ_DEPTH),
    .RESP_DEPTH (RESP_DEPTH),
    .MEM_LINES  (256),
    .MEM_LATENCY(4)
  ) i_cache_top (
    .clk, .reset, .req_valid, .req, .req_credit, .resp_valid, .resp, .resp_credit
  );

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  function automatic cache_pkg::addr_t make_addr(input int tag, input int set_idx, input int word);
    return cache_pkg::addr_t'((tag << TAG_LSB) | (set_idx << 4) | (word << 2));
  endfunction

  // Predicts the response and advances the model with the cache's victim and LRU rules
  function automatic cache_pkg::cache_resp_t ref_access(input cache_pkg::cache_req_t r);
    cache_pkg::cache_resp_t expected;
    cache_pkg::addr_t       tag;
    int                     set_idx;
    int                     widx;
    int                     way;
    set_idx = int'(r.addr[TAG_LSB-1:4]);
    tag = r.addr >> TAG_LSB;
    widx = int'(r.addr[11:2]);
    way = -1;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (ref_valid[set_idx][w] && (ref_tag[set_idx][w] == tag)) way = w;
    end
    expected.hit = (way >= 0);
    // Empty way first, then the LRU way
    if (way < 0) begin
      if (!ref_valid[set_idx][0]) way = 0;
      else if (!ref_valid[set_idx][1]) way = 1;
      else way = int'(ref_lru[set_idx]);
    end
    ref_valid[set_idx][way] = 1'b1;
    ref_tag[set_idx][way] = tag;
    ref_lru[set_idx] = (way == 0);
    if (r.write) ref_mem[widx] = r.wdata;
    expected.write = r.write;
    // Write data is echoed, so this covers both kinds
    expected.rdata = ref_mem[widx];
    return expected;
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp_word);
    checks++;
    if (got !== exp_word) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp_word);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp_flag);
    checks++;
    if (got !== exp_flag) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp_flag);
    end
  endtask

  task automatic check_resp(input cache_pkg::cache_resp_t got,
                            input cache_pkg::cache_resp_t exp_resp);
    check_flag("resp.write", got.write, exp_resp.write);
    check_flag("resp.hit", got.hit, exp_resp.hit);
    check_word("resp.rdata", got.rdata, exp_resp.rdata);
  endtask

  // Waits on zero credits, then drives one request for one cycle
  task automatic send_req(input logic write, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t data);
    cache_pkg::cache_req_t r;
    r.write = write;
    r.addr = addr;
    r.wdata = data;
    while (sent - credits_back >= REQ_DEPTH) begin
      req_valid = 1'b0;
      stall_cycles++;
      @(posedge clk);
      #10;
    end
    req_valid = 1'b1;
    req = r;
    exp_mem[sent] = ref_access(r);
    sent++;
    @(posedge clk);
    #10;
    req_valid = 1'b0;
  endtask

  // Op, then seven address bits covering 32 lines, then data
  task automatic random_req();
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] d;
    draw_bits(stim_lfsr, 1, op);
    draw_bits(stim_lfsr, 7, a);
    draw_bits(stim_lfsr, 32, d);
    send_req(op[0], {23'd0, a[6:0], 2'b00}, d);
  endtask

  task automatic drain();
    @(posedge clk);
    while (exp_rd != sent) @(posedge clk);
    #10;
  endtask

  task automatic report_test(input int num, input string name, input int req_mark,
                             input int err_mark);
    $display("test %0d %s: %0d requests, %0d errors", num, name, sent - req_mark,
             errors - err_mark);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Outputs sampled at the falling edge, where they are stable
  always @(negedge clk) begin
    if (!reset && req_credit) begin
      if (sent - credits_back <= 0) begin
        errors++;
        $display("Error: request credit returned with no request outstanding");
      end else begin
        credits_back++;
      end
    end
    if (!reset && resp_valid) begin
      absorbed++;
      if (exp_rd == sent) begin
        errors++;
        $display("Error: response arrived with no request outstanding");
      end else begin
        check_resp(resp, exp_mem[exp_rd]);
        exp_rd++;
      end
    end
  end

  // Consumer returns one credit per absorbed response, delayed in slow mode
  initial begin
    logic [31:0] bits;
    int          gap;
    int          returned;
    resp_credit = 1'b0;
    credit_lfsr = 32'hc1c5;
    gap = 0;
    returned = 0;
    forever begin
      @(posedge clk);
      #10;
      resp_credit = 1'b0;
      if (gap > 0) begin
        gap--;
      end else if (absorbed > returned) begin
        resp_credit = 1'b1;
        returned++;
        if (slow_consumer) begin
          draw_bits(credit_lfsr, 3, bits);
          gap = int'(bits[2:0]);
        end
      end
    end
  end

  // Hang guard
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [31:0] bits;
    int          req_mark;
    int          err_mark;
    int          stall_mark;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    slow_consumer = 1'b0;
    stim_lfsr = 32'hc1c5;
    sent = 0;
    stall_cycles = 0;
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      ref_valid[s] = '0;
      ref_lru[s] = 1'b0;
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) ref_tag[s][w] = '0;
    end
    repeat (16) @(posedge clk);
    #10;
    reset = 1'b0;

    // Write then read each set, first access misses
    req_mark = sent;
    err_mark = errors;
    for (int s = 0; s < NUM_SETS; s++) begin
      draw_bits(stim_lfsr, 32, bits);
      send_req(1'b1, make_addr(1, s, s % 4), bits);
      send_req(1'b0, make_addr(1, s, s % 4), '0);
    end
    drain();
    report_test(1, "write then read", req_mark, err_mark);

    // Three tags in set 3
    req_mark = sent;
    err_mark = errors;
    send_req(1'b1, make_addr(4, 3, 0), 32'h0a0a_0001);
    send_req(1'b1, make_addr(5, 3, 1), 32'h0b0b_0002);
    // Tag 5 becomes LRU
    send_req(1'b0, make_addr(4, 3, 0), '0);
    // Evicts dirty tag 5 through a writeback
    send_req(1'b1, make_addr(6, 3, 2), 32'h0c0c_0003);
    send_req(1'b0, make_addr(5, 3, 1), '0);
    send_req(1'b0, make_addr(6, 3, 2), '0);
    drain();
    report_test(2, "eviction", req_mark, err_mark);

    // Lines never written
    req_mark = sent;
    err_mark = errors;
    for (int s = 0; s < NUM_SETS; s++) begin
      send_req(1'b0, make_addr(24 + s, s, (s + 1) % 4), '0);
    end
    drain();
    report_test(3, "unwritten reads", req_mark, err_mark);

    req_mark = sent;
    err_mark = errors;
    for (int i = 0; i < T4_REQS; i++) random_req();
    drain();
    report_test(4, "random full rate", req_mark, err_mark);

    // Consumer credits come back late
    req_mark = sent;
    err_mark = errors;
    stall_mark = stall_cycles;
    slow_consumer = 1'b1;
    for (int i = 0; i < T5_REQS; i++) random_req();
    drain();
    // Back-pressure must reach the requester
    if (stall_cycles == stall_mark) begin
      errors++;
      $display("Error: requester never stalled on zero credits");
    end
    report_test(5, "slow consumer", req_mark, err_mark);
    $display("requester stalled %0d cycles on zero credits", stall_cycles - stall_mark);

    $display("%0d requests, %0d responses, %0d checks, %0d errors", sent, exp_rd,
             checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
logic/cache_pkg.sv
logic/req_intake.sv
logic/cache_ctrl.sv
logic/line_memory.sv
logic/resp_queue.sv
logic/cache_top.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// ==== Makefile ====
TOP := cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "SIM FAILED"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then echo "SIM FAILED"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
